// ==== Bender.yml ====
package:
  name: cpuMemPath

sources:
  - hw/cpuMemPkg.sv
  - hw/memBusIf.sv
  - hw/memoryHandler.sv
  - hw/loadStoreFormat.sv
  - hw/memBusCtrl.sv
  - hw/instrLatch.sv
  - hw/cpuMemPath.sv
  - target: simulation
    files:
      - sim/cpuMemPath_properties.sv
      - sim/cpuMemPath_tb.sv

// ==== cpuMemPath.f ====
hw/cpuMemPkg.sv
hw/memBusIf.sv
hw/memoryHandler.sv
hw/loadStoreFormat.sv
hw/memBusCtrl.sv
hw/instrLatch.sv
hw/cpuMemPath.sv
sim/cpuMemPath_properties.sv
sim/cpuMemPath_tb.sv

// ==== hw/cpuMemPath.sv ====
module cpuMemPath
    import cpuMemPkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  logic [XLEN-1:0]  pc,
    input  logic [XLEN-1:0]  aluAddress,
    input  MemOpT            memOp,
    input  logic             memWrite,
    input  logic             memRead,
    input  logic             memSource,
    input  logic [XLEN-1:0]  fpuData,
    input  logic [XLEN-1:0]  regData,
    input  logic             memAck,
    input  logic [XLEN-1:0]  memRdata,
    output logic [XLEN-1:0]  instr,
    output logic [XLEN-1:0]  dataToCPU,
    output logic             freeze,
    output logic             fetchRead,
    output logic             addrControl,
    output logic             memReq,
    output logic             memWe,
    output logic [XLEN-1:0]  memAddr,
    output logic [XLEN-1:0]  memWdata
);

    memBusIf bus ();                          // Handler to bus controller link

    logic fetchDone;

    memoryHandler i_memoryHandler (
        .clk         (clk),
        .nrst        (nrst),
        .pc          (pc),
        .aluAddress  (aluAddress),
        .memWrite    (memWrite),
        .memRead     (memRead),
        .bus         (bus.handler),
        .freeze      (freeze),
        .fetchRead   (fetchRead),
        .addrControl (addrControl),
        .fetchDone   (fetchDone)
    );

    // Store data joins the bus on the handler side
    loadStoreFormat i_loadStoreFormat (
        .memOp     (memOp),
        .memSource (memSource),
        .fpuData   (fpuData),
        .regData   (regData),
        .rdata     (bus.rdata),
        .wdata     (bus.wdata),
        .dataToCPU (dataToCPU)
    );

    memBusCtrl i_memBusCtrl (
        .clk      (clk),
        .nrst     (nrst),
        .memAck   (memAck),
        .memRdata (memRdata),
        .bus      (bus.ctrl),
        .memReq   (memReq),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata)
    );

    instrLatch i_instrLatch (
        .clk   (clk),
        .nrst  (nrst),
        .load  (fetchDone),
        .rdata (bus.rdata),
        .instr (instr)
    );

endmodule

// ==== hw/cpuMemPkg.sv ====
package cpuMemPkg;

    localparam int XLEN = 32;                  // Data and address width

    // Load/store operation code from the control unit
    typedef logic [3:0] MemOpT;

    localparam MemOpT MEM_LB  = 4'd1;          // Load byte, sign extended
    localparam MemOpT MEM_LH  = 4'd2;          // Load half, sign extended
    localparam MemOpT MEM_LW  = 4'd3;          // Load word
    localparam MemOpT MEM_LBU = 4'd4;          // Load byte, zero extended
    localparam MemOpT MEM_LHU = 4'd5;          // Load half, zero extended
    localparam MemOpT MEM_SB  = 4'd6;          // Store byte
    localparam MemOpT MEM_SH  = 4'd7;          // Store half
    localparam MemOpT MEM_SW  = 4'd8;          // Store word

    // One-cycle command from handler to bus controller
    typedef enum logic [1:0] {
        RWI_IDLE  = 2'b00,
        RWI_READ  = 2'b01,
        RWI_WRITE = 2'b10,
        RWI_FETCH = 2'b11
    } RwiT;

    // Memory handler sequence
    typedef enum logic [1:0] {
        FETCH  = 2'd0,                         // Issue instruction fetch
        F_WAIT = 2'd1,                         // Wait for fetch to complete
        DATA   = 2'd2,                         // Issue load/store if any
        D_WAIT = 2'd3                          // Wait for data access
    } StateT;

endpackage

// ==== hw/instrLatch.sv ====
module instrLatch
    import cpuMemPkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  logic             load,            // End of a fetch
    input  logic [XLEN-1:0]  rdata,
    output logic [XLEN-1:0]  instr            // Held for the decoder
);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            instr <= '0;
        end else if (load) begin
            instr <= rdata;
        end
    end

endmodule

// ==== hw/loadStoreFormat.sv ====
module loadStoreFormat
    import cpuMemPkg::*;
(
    input  MemOpT            memOp,
    input  logic             memSource,       // 1 stores from FPU, 0 from register file
    input  logic [XLEN-1:0]  fpuData,
    input  logic [XLEN-1:0]  regData,
    input  logic [XLEN-1:0]  rdata,           // Held read word from the bus
    output logic [XLEN-1:0]  wdata,           // Sized store data
    output logic [XLEN-1:0]  dataToCPU        // Extended load data
);

    logic [XLEN-1:0] storeSrc;

    assign storeSrc = memSource ? fpuData : regData;

    // Store sizing, zero filled above the stored field
    always_comb begin
        case (memOp)
            MEM_SB:  wdata = {{(XLEN-8){1'b0}}, storeSrc[7:0]};
            MEM_SH:  wdata = {{(XLEN-16){1'b0}}, storeSrc[15:0]};
            MEM_SW:  wdata = storeSrc;
            default: wdata = '0;              // Loads and invalid codes
        endcase
    end

    // Load sizing and extension
    always_comb begin
        case (memOp)
            MEM_LB: begin
                dataToCPU = {{(XLEN-8){rdata[7]}}, rdata[7:0]};
            end
            MEM_LH: begin
                dataToCPU = {{(XLEN-16){rdata[15]}}, rdata[15:0]};
            end
            MEM_LW: begin
                dataToCPU = rdata;
            end
            MEM_LBU: begin
                dataToCPU = {{(XLEN-8){1'b0}}, rdata[7:0]};
            end
            MEM_LHU: begin
                dataToCPU = {{(XLEN-16){1'b0}}, rdata[15:0]};
            end
            default: begin
                dataToCPU = '0;               // Stores and invalid codes
            end
        endcase
    end

endmodule

// ==== hw/memBusCtrl.sv ====
module memBusCtrl
    import cpuMemPkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  logic             memAck,          // One-cycle acknowledge from memory
    input  logic [XLEN-1:0]  memRdata,        // Valid with memAck
    memBusIf.ctrl            bus,
    output logic             memReq,          // Held until memAck
    output logic             memWe,
    output logic [XLEN-1:0]  memAddr,
    output logic [XLEN-1:0]  memWdata
);

    logic newCmd;

    // Only one access in flight, a command while busy is dropped
    assign newCmd = (bus.rwi != RWI_IDLE) && !memReq;

    // Request level and write flag
    always_ff @(posedge clk) begin
        if (!nrst) begin
            memReq <= 1'b0;
            memWe  <= 1'b0;
        end else if (memReq && memAck) begin
            memReq <= 1'b0;                   // Drops the cycle after acknowledge
            memWe  <= 1'b0;
        end else if (newCmd) begin
            memReq <= 1'b1;
            memWe  <= (bus.rwi == RWI_WRITE); // Fetch goes out as a read
        end
    end

    // Request fields stay stable until acknowledge
    always_ff @(posedge clk) begin
        if (newCmd) begin
            memAddr  <= bus.addr;
            memWdata <= bus.wdata;
        end
    end

    // Keep the read word for the formatter and instruction latch
    always_ff @(posedge clk) begin
        if (memReq && memAck && !memWe) begin
            bus.rdata <= memRdata;
        end
    end

    assign bus.busy = memReq;

endmodule

// ==== hw/memBusIf.sv ====
interface memBusIf
    import cpuMemPkg::*;
();

    RwiT              rwi;                     // Command pulse, idle otherwise
    logic [XLEN-1:0]  addr;                    // Access address
    logic [XLEN-1:0]  wdata;                   // Sized store data
    logic [XLEN-1:0]  rdata;                   // Last read word, held
    logic             busy;                    // High while an access is in flight

    // Core side, issues commands and sees completion
    modport handler (
        output rwi,
        output addr,
        output wdata,
        input  rdata,
        input  busy
    );

    // Bus side, accepts commands and reports status
    modport ctrl (
        input  rwi,
        input  addr,
        input  wdata,
        output rdata,
        output busy
    );

endinterface

// ==== hw/memoryHandler.sv ====
module memoryHandler
    import cpuMemPkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  logic [XLEN-1:0]  pc,              // Fetch address
    input  logic [XLEN-1:0]  aluAddress,      // Load/store address
    input  logic             memWrite,
    input  logic             memRead,
    memBusIf.handler         bus,
    output logic             freeze,          // Stalls the core during an access
    output logic             fetchRead,       // High while fetch is issued
    output logic             addrControl,     // 0 selects pc, 1 selects aluAddress
    output logic             fetchDone        // Fetch word is ready on rdata
);

    StateT state;
    StateT stateNext;
    logic  prevBusy;                          // Busy from last cycle
    logic  busyFall;

    // Falling edge of busy marks the end of an access
    always_ff @(posedge clk) begin
        if (!nrst) begin
            prevBusy <= 1'b0;
        end else begin
            prevBusy <= bus.busy;
        end
    end

    assign busyFall = prevBusy & ~bus.busy;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= FETCH;                   // First cycle out of reset fetches
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        bus.rwi   = RWI_IDLE;
        unique case (state)
            FETCH: begin
                bus.rwi   = RWI_FETCH;
                stateNext = F_WAIT;           // Always a single cycle
            end
            F_WAIT: begin
                if (busyFall) begin
                    stateNext = DATA;
                end
            end
            DATA: begin
                if (memWrite) begin           // Store takes priority
                    bus.rwi   = RWI_WRITE;
                    stateNext = D_WAIT;
                end else if (memRead) begin
                    bus.rwi   = RWI_READ;
                    stateNext = D_WAIT;
                end else begin
                    stateNext = FETCH;        // No data access this instruction
                end
            end
            D_WAIT: begin
                if (busyFall) begin
                    stateNext = FETCH;
                end
            end
            default: stateNext = FETCH;
        endcase
    end

    // Freeze everywhere except the fetch issue cycle
    assign freeze      = (state != FETCH);
    assign fetchRead   = (state == FETCH);
    assign addrControl = (state == DATA) || (state == D_WAIT);
    assign fetchDone   = (state == F_WAIT) && busyFall;

    // Address mux
    assign bus.addr = addrControl ? aluAddress : pc;

endmodule

// ==== sim/cpuMemPath_properties.sv ====
module cpuMemPath_properties
    import cpuMemPkg::*;
(
    input logic             clk,
    input logic             nrst,
    input logic [XLEN-1:0]  pc,
    input logic [XLEN-1:0]  aluAddress,
    input MemOpT            memOp,
    input logic             memWrite,
    input logic             memRead,
    input logic             memSource,
    input logic [XLEN-1:0]  fpuData,
    input logic [XLEN-1:0]  regData,
    input logic             memAck,
    input logic [XLEN-1:0]  memRdata,
    input logic [XLEN-1:0]  instr,
    input logic [XLEN-1:0]  dataToCPU,
    input logic             freeze,
    input logic             fetchRead,
    input logic             addrControl,
    input logic             memReq,
    input logic             memWe,
    input logic [XLEN-1:0]  memAddr,
    input logic [XLEN-1:0]  memWdata
);

    int              errCount = 0;            // Read by the testbench at the end
    logic [XLEN-1:0] lastRead;                // Word of the last read acknowledge
    logic            lastWasLoad;             // Last acknowledged access was a data read

    // Store field picked from the selected source, upper bits cleared
    function automatic logic [XLEN-1:0] storeExpect(input MemOpT op, input logic src,
                                                    input logic [XLEN-1:0] fpu,
                                                    input logic [XLEN-1:0] rf);
        logic [XLEN-1:0] v;
        v = src ? fpu : rf;
        if (op == MEM_SB) return v & 32'h0000_00FF;
        if (op == MEM_SH) return v & 32'h0000_FFFF;
        if (op == MEM_SW) return v;
        return '0;
    endfunction

    // Low byte or half of the word, signed or unsigned
    function automatic logic [XLEN-1:0] loadExpect(input MemOpT op, input logic [XLEN-1:0] w);
        if (op == MEM_LB)  return 32'($signed(w[7:0]));
        if (op == MEM_LH)  return 32'($signed(w[15:0]));
        if (op == MEM_LW)  return w;
        if (op == MEM_LBU) return w & 32'h0000_00FF;
        if (op == MEM_LHU) return w & 32'h0000_FFFF;
        return '0;
    endfunction

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lastRead    <= '0;
            lastWasLoad <= 1'b0;
        end else if (memReq && memAck) begin
            if (!memWe) lastRead <= memRdata;
            lastWasLoad <= addrControl && !memWe;  // Fetch acks clear it
        end
    end

    // Fetched word reaches instr two cycles after the acknowledge
    fetchWord: assert property (@(posedge clk) disable iff (!nrst)
        memReq && memAck && !memWe && !addrControl |=> ##1 instr == $past(memRdata, 2))
        else begin
            errCount++;
            $error("[FAIL] %0t instr differs from fetched word", $time);
        end

    fetchAddr: assert property (@(posedge clk) disable iff (!nrst)
        $rose(memReq) && !addrControl |-> memAddr == $past(pc))
        else begin
            errCount++;
            $error("[FAIL] %0t fetch address differs from pc", $time);
        end

    dataAddr: assert property (@(posedge clk) disable iff (!nrst)
        memReq && addrControl |-> memAddr == aluAddress)
        else begin
            errCount++;
            $error("[FAIL] %0t data address differs", $time);
        end

    storeData: assert property (@(posedge clk) disable iff (!nrst)
        memReq && memWe |-> memWdata == storeExpect(memOp, memSource, fpuData, regData))
        else begin
            errCount++;
            $error("[FAIL] %0t store data wrongly sized", $time);
        end

    loadData: assert property (@(posedge clk) disable iff (!nrst)
        $fell(freeze) && lastWasLoad |-> dataToCPU == loadExpect(memOp, lastRead))
        else begin
            errCount++;
            $error("[FAIL] %0t load data wrongly extended", $time);
        end

    // Single fetch issue cycle, flagged, then frozen with a read request out
    freezeFetch: assert property (@(posedge clk) disable iff (!nrst)
        !freeze |-> fetchRead ##1 (freeze && !fetchRead && memReq && !memWe))
        else begin
            errCount++;
            $error("[FAIL] %0t freeze or fetch request wrong", $time);
        end

    // Data cycle requests only for a load or store, and writes only for a store
    dataRequest: assert property (@(posedge clk) disable iff (!nrst)
        $rose(addrControl) |=> memReq == $past(memRead || memWrite) && memWe == $past(memWrite))
        else begin
            errCount++;
            $error("[FAIL] %0t data request does not match load or store", $time);
        end

    reqStable: assert property (@(posedge clk) disable iff (!nrst)
        memReq && !memAck |=> memReq && $stable(memWe) && $stable(memAddr) && $stable(memWdata))
        else begin
            errCount++;
            $error("[FAIL] %0t request changed before ack", $time);
        end

    reqDrop: assert property (@(posedge clk) disable iff (!nrst)
        memReq && memAck |=> !memReq)
        else begin
            errCount++;
            $error("[FAIL] %0t request held after ack", $time);
        end

    resetFetch: assert property (@(posedge clk) disable iff (!nrst)
        $rose(nrst) |-> !memReq ##1 (memReq && !memWe))
        else begin
            errCount++;
            $error("[FAIL] %0t no fetch after reset", $time);
        end

endmodule

bind cpuMemPath cpuMemPath_properties i_props (.*);

// ==== sim/cpuMemPath_tb.sv ====
module cpuMemPath_tb
    import cpuMemPkg::*;
();

    localparam int NUM_OPS    = 60;
    localparam int MAX_CYCLES = NUM_OPS * 14 + 20;  // Worst case fetch plus data, reset, drain
    localparam int MEM_WORDS  = 16;

    logic            clk;
    logic            nrst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] aluAddress;
    MemOpT           memOp;
    logic            memWrite;
    logic            memRead;
    logic            memSource;
    logic [XLEN-1:0] fpuData;
    logic [XLEN-1:0] regData;
    logic            memAck = 1'b0;            // Owned by the memory model
    logic [XLEN-1:0] memRdata = '0;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] dataToCPU;
    logic            freeze;
    logic            fetchRead;
    logic            addrControl;
    logic            memReq;
    logic            memWe;
    logic [XLEN-1:0] memAddr;
    logic [XLEN-1:0] memWdata;

    logic [XLEN-1:0] memArray [MEM_WORDS];
    logic [31:0]     stimRng;
    logic [31:0]     memRng;
    logic            pending;                  // Request seen, ack delay running
    int              delayLeft;
    int              opsDone;
    int              cycleCount;
    int              errors;

    cpuMemPath i_cpuMemPath (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Control unit: next instruction while the fetch is in flight
    task automatic issueOp();
        logic [31:0] r;
        stimRng = xorshift(stimRng);
        r = stimRng;
        pc         <= (pc + 32'd4) & 32'h3C;   // Stays inside the model array
        aluAddress <= {26'd0, r[5:2], 2'b00};
        memSource  <= r[6];
        case (r[9:8])
            2'd0: begin                        // Load of any width
                memOp    <= MemOpT'(1 + (r[13:10] % 5));
                memRead  <= 1'b1;
                memWrite <= 1'b0;
            end
            2'd1: begin                        // Store of any width
                memOp    <= MemOpT'(6 + (r[13:10] % 3));
                memRead  <= 1'b0;
                memWrite <= 1'b1;
            end
            default: begin
                memOp    <= MemOpT'(r[13:10]); // Any code, no access
                memRead  <= 1'b0;
                memWrite <= 1'b0;
            end
        endcase
        stimRng = xorshift(stimRng);
        fpuData <= stimRng;
        stimRng = xorshift(stimRng);
        regData <= stimRng;
    endtask

    // Memory model, acknowledges 1 to 4 cycles after the request rises
    always @(posedge clk) begin : memModel
        int   i;
        logic ackNow;
        memAck <= 1'b0;
        ackNow = 1'b0;
        if (!nrst) begin
            pending   <= 1'b0;
            delayLeft <= 0;
            memRng = 32'd27;
            for (i = 0; i < MEM_WORDS; i++) begin
                memArray[i] <= (32'h9E37_79B9 * (i + 1)) ^ (i << 20);
            end
        end else if (memReq && !memAck) begin
            if (!pending) begin
                memRng = xorshift(memRng);
                delayLeft <= memRng % 4;
                pending   <= 1'b1;
                ackNow    = (memRng % 4 == 0);  // Shortest delay, ack right away
            end else begin
                delayLeft <= delayLeft - 1;
                ackNow    = (delayLeft == 1);
            end
            if (ackNow) begin
                memAck   <= 1'b1;
                memRdata <= memArray[memAddr[5:2]];
                if (memWe) memArray[memAddr[5:2]] <= memWdata;
                pending  <= 1'b0;
            end
        end
    end

    initial begin
        nrst       <= 1'b0;
        pc         <= '0;
        aluAddress <= '0;
        memOp      <= MemOpT'(0);
        memWrite   <= 1'b0;
        memRead    <= 1'b0;
        memSource  <= 1'b0;
        fpuData    <= '0;
        regData    <= '0;
        stimRng = 32'd27;
        opsDone = 0;
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        while (opsDone < NUM_OPS) begin
            @(posedge clk);
            if (!freeze) begin                 // Fetch was issued last cycle
                issueOp();
                opsDone++;
            end
        end
        do @(posedge clk); while (freeze);     // Let the last instruction complete
        repeat (2) @(posedge clk);
        errors = i_cpuMemPath.i_props.errCount;
        $display("Assertion failures: %0d, operations run: %0d", errors, opsDone);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycleCount = 0;
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule
